/* serial_rv32.f */
+incdir+tests
source/serial_rv32_pkg.sv
source/issue_if.sv
source/fetch_unit.sv
source/instr_decode.sv
source/reg_file.sv
source/serial_execute.sv
source/result_commit.sv
source/serial_rv32_top.sv
tests/tb_serial_rv32.sv

/* source/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
   parameter serial_rv32_pkg::word_t RESET_PC = 32'h0
) (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  logic                   i_retire,
   input  serial_rv32_pkg::word_t i_ibus_dat,
   input  logic                   i_ibus_ack,
   output serial_rv32_pkg::word_t o_ibus_adr,
   output logic                   o_ibus_cyc,
   output logic                   o_ibus_stb,
   output serial_rv32_pkg::word_t o_instr,
   output logic                   o_instr_valid
);
   import serial_rv32_pkg::*;

   word_t      pc;
   logic       pending;
   logic [1:0] boot;
   logic       launch;

   // First fetch opens in the second cycle out of reset
   assign launch = boot[0] & ~boot[1];

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         boot    <= 2'b00;
         pending <= 1'b0;
         pc      <= RESET_PC;
      end else begin
         boot <= {boot[0], 1'b1};
         if (i_retire) begin
            pc <= pc + 32'd4;
         end
         if (launch || i_retire) begin
            pending <= 1'b1;
         end else if (pending && i_ibus_ack) begin
            pending <= 1'b0;
         end
      end
   end

   assign o_ibus_adr    = pc;
   assign o_ibus_cyc    = pending;
   assign o_ibus_stb    = pending;
   assign o_instr       = i_ibus_dat;
   assign o_instr_valid = pending & i_ibus_ack;

endmodule

`default_nettype wire

/* source/instr_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_decode (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  serial_rv32_pkg::word_t     i_instr,
   input  logic                       i_instr_valid,
   output serial_rv32_pkg::reg_addr_t o_rs1_addr,
   output serial_rv32_pkg::reg_addr_t o_rs2_addr,
   issue_if.decode                    issue
);
   import serial_rv32_pkg::*;

   instr_u instr;
   logic   is_lui;

   always_ff @(posedge clk) begin
      if (i_instr_valid) begin
         instr <= i_instr;
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         issue.start <= 1'b0;
      end else begin
         issue.start <= i_instr_valid;
      end
   end

   always_comb begin
      issue.alu_op    = ALU_ADD;
      issue.use_imm   = 1'b1;
      issue.imm       = {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm};
      issue.rd        = instr.r.rd;
      issue.writes_rd = 1'b0;
      issue.is_store  = 1'b0;
      is_lui          = 1'b0;
      case (instr.r.opcode)
         OP: begin
            issue.use_imm   = 1'b0;
            issue.writes_rd = 1'b1;
            case (instr.r.funct3)
               3'b000:  issue.alu_op = instr.r.funct7[5] ? ALU_SUB : ALU_ADD;
               3'b100:  issue.alu_op = ALU_XOR;
               3'b110:  issue.alu_op = ALU_OR;
               3'b111:  issue.alu_op = ALU_AND;
               default: issue.writes_rd = 1'b0;
            endcase
         end
         OP_IMM: begin
            issue.writes_rd = 1'b1;
            case (instr.i.funct3)
               3'b000:  issue.alu_op = ALU_ADD;
               3'b100:  issue.alu_op = ALU_XOR;
               3'b110:  issue.alu_op = ALU_OR;
               3'b111:  issue.alu_op = ALU_AND;
               default: issue.writes_rd = 1'b0;
            endcase
         end
         // Add of the upper immediate to x0
         LUI: begin
            issue.imm       = {instr.u.imm, 12'b0};
            issue.writes_rd = 1'b1;
            is_lui          = 1'b1;
         end
         STORE: begin
            issue.imm      = {{(XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            issue.is_store = (instr.s.funct3 == 3'b010);
         end
         default: begin
            issue.writes_rd = 1'b0;
         end
      endcase
   end

   assign o_rs1_addr = is_lui ? 5'd0 : instr.r.rs1;
   assign o_rs2_addr = instr.r.rs2;

endmodule

`default_nettype wire

/* source/issue_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface issue_if;
   import serial_rv32_pkg::*;

   // One-cycle pulse that launches the serial run
   logic      start;
   alu_op_t   alu_op;
   logic      use_imm;
   word_t     imm;
   reg_addr_t rd;
   logic      writes_rd;
   logic      is_store;

   modport decode (
      output start,
      output alu_op,
      output use_imm,
      output imm,
      output rd,
      output writes_rd,
      output is_store
   );

   modport execute (
      input start,
      input alu_op,
      input use_imm,
      input imm
   );

   modport result (
      input start,
      input rd,
      input writes_rd,
      input is_store
   );

endinterface

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
   input  logic                       clk,
   input  serial_rv32_pkg::reg_addr_t i_rs1_addr,
   input  serial_rv32_pkg::reg_addr_t i_rs2_addr,
   input  logic                       i_we,
   input  serial_rv32_pkg::reg_addr_t i_waddr,
   input  serial_rv32_pkg::word_t     i_wdata,
   output serial_rv32_pkg::word_t     o_rs1,
   output serial_rv32_pkg::word_t     o_rs2
);
   import serial_rv32_pkg::*;

   word_t regs [32];

   always_ff @(posedge clk) begin
      if (i_we && (i_waddr != 5'd0)) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   // x0 never holds a written value
   assign o_rs1 = (i_rs1_addr == 5'd0) ? '0 : regs[i_rs1_addr];
   assign o_rs2 = (i_rs2_addr == 5'd0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

/* source/result_commit.sv */
`timescale 1ns/100ps
`default_nettype none

module result_commit (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_res_bit,
   input  logic                       i_res_valid,
   input  logic                       i_done,
   input  serial_rv32_pkg::word_t     i_store_data,
   input  logic                       i_dbus_ack,
   output logic                       o_rf_we,
   output serial_rv32_pkg::reg_addr_t o_rf_waddr,
   output serial_rv32_pkg::word_t     o_rf_wdata,
   output logic                       o_retire,
   output serial_rv32_pkg::word_t     o_dbus_adr,
   output serial_rv32_pkg::word_t     o_dbus_dat,
   output logic                       o_dbus_we,
   output logic                       o_dbus_cyc,
   output logic                       o_dbus_stb,
   issue_if.result                    issue
);
   import serial_rv32_pkg::*;

   word_t res;
   word_t res_next;
   logic  busy;
   logic  done_q;
   logic  store_ack_q;

   // Result bits arrive LSB first
   assign res_next = {i_res_bit, res[XLEN-1:1]};

   always_ff @(posedge clk) begin
      if (i_res_valid) begin
         res <= res_next;
      end
   end

   // Last bit lands in the address directly
   always_ff @(posedge clk) begin
      if (i_done && issue.is_store) begin
         o_dbus_adr <= res_next;
         o_dbus_dat <= i_store_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         busy        <= 1'b0;
         done_q      <= 1'b0;
         store_ack_q <= 1'b0;
         o_dbus_cyc  <= 1'b0;
         o_dbus_we   <= 1'b0;
      end else begin
         done_q      <= i_done & busy & ~issue.is_store;
         store_ack_q <= o_dbus_cyc & i_dbus_ack;
         if (issue.start) begin
            busy <= 1'b1;
         end else if (o_retire) begin
            busy <= 1'b0;
         end
         if (i_done && busy && issue.is_store) begin
            o_dbus_cyc <= 1'b1;
            o_dbus_we  <= 1'b1;
         end else if (o_dbus_cyc && i_dbus_ack) begin
            o_dbus_cyc <= 1'b0;
            o_dbus_we  <= 1'b0;
         end
      end
   end

   assign o_dbus_stb = o_dbus_cyc;
   assign o_rf_we    = done_q & issue.writes_rd;
   assign o_rf_waddr = issue.rd;
   assign o_rf_wdata = res;
   // Stores retire after the bus ack, everything else after done
   assign o_retire   = done_q | store_ack_q;

endmodule

`default_nettype wire

/* source/serial_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module serial_execute (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  serial_rv32_pkg::word_t i_rs1,
   input  serial_rv32_pkg::word_t i_rs2,
   output logic                   o_res_bit,
   output logic                   o_res_valid,
   output logic                   o_done,
   issue_if.execute               issue
);
   import serial_rv32_pkg::*;

   word_t      op_a;
   word_t      op_b;
   logic [4:0] cnt;
   logic       active;
   logic       carry;
   logic       sub;
   logic       b_bit;
   logic       sum_bit;

   assign sub     = (issue.alu_op == ALU_SUB);
   // Subtract adds the inverted operand with carry preset
   assign b_bit   = op_b[0] ^ sub;
   assign sum_bit = op_a[0] ^ b_bit ^ carry;

   always_comb begin
      case (issue.alu_op)
         ALU_XOR: o_res_bit = op_a[0] ^ op_b[0];
         ALU_OR:  o_res_bit = op_a[0] | op_b[0];
         ALU_AND: o_res_bit = op_a[0] & op_b[0];
         default: o_res_bit = sum_bit;
      endcase
   end

   assign o_res_valid = active;
   assign o_done      = active && (cnt == 5'd31);

   // Operands shift out LSB first
   always_ff @(posedge clk) begin
      if (issue.start) begin
         op_a <= i_rs1;
         op_b <= issue.use_imm ? issue.imm : i_rs2;
      end else if (active) begin
         op_a <= {1'b0, op_a[XLEN-1:1]};
         op_b <= {1'b0, op_b[XLEN-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         active <= 1'b0;
         cnt    <= 5'd0;
         carry  <= 1'b0;
      end else if (issue.start) begin
         active <= 1'b1;
         cnt    <= 5'd0;
         carry  <= sub;
      end else if (active) begin
         cnt   <= cnt + 5'd1;
         carry <= (op_a[0] & b_bit) | (carry & (op_a[0] ^ b_bit));
         if (cnt == 5'd31) begin
            active <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* source/serial_rv32_pkg.sv */
`default_nettype none

package serial_rv32_pkg;

   parameter int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [4:0]      reg_addr_t;

   // Major opcodes of the kept instruction groups
   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OP_IMM = 7'b0010011,
      LUI    = 7'b0110111,
      STORE  = 7'b0100011
   } opcode_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_OR,
      ALU_AND
   } alu_op_t;

   typedef struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      opcode_t    opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      opcode_t     opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      opcode_t    opcode;
   } s_fmt_t;

   typedef struct packed {
      logic [19:0] imm;
      reg_addr_t   rd;
      opcode_t     opcode;
   } u_fmt_t;

   // One fetched word, read in the layout its opcode selects
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      s_fmt_t s;
      u_fmt_t u;
   } instr_u;

endpackage

`default_nettype wire

/* source/serial_rv32_top.sv */
`timescale 1ns/100ps
`default_nettype none

module serial_rv32_top #(
   parameter serial_rv32_pkg::word_t RESET_PC = 32'h0
) (
   input  logic                   clk,
   input  logic                   i_rst_n,
   output serial_rv32_pkg::word_t o_ibus_adr,
   output logic                   o_ibus_cyc,
   output logic                   o_ibus_stb,
   input  serial_rv32_pkg::word_t i_ibus_dat,
   input  logic                   i_ibus_ack,
   output serial_rv32_pkg::word_t o_dbus_adr,
   output serial_rv32_pkg::word_t o_dbus_dat,
   output logic                   o_dbus_we,
   output logic                   o_dbus_cyc,
   output logic                   o_dbus_stb,
   input  logic                   i_dbus_ack
);
   import serial_rv32_pkg::*;

   word_t     instr;
   logic      instr_valid;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   word_t     rs1;
   word_t     rs2;
   logic      res_bit;
   logic      res_valid;
   logic      done;
   logic      rf_we;
   reg_addr_t rf_waddr;
   word_t     rf_wdata;
   logic      retire;

   issue_if issue ();

   fetch_unit #(
      .RESET_PC (RESET_PC)
   ) u_fetch (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_retire      (retire),
      .i_ibus_dat    (i_ibus_dat),
      .i_ibus_ack    (i_ibus_ack),
      .o_ibus_adr    (o_ibus_adr),
      .o_ibus_cyc    (o_ibus_cyc),
      .o_ibus_stb    (o_ibus_stb),
      .o_instr       (instr),
      .o_instr_valid (instr_valid)
   );

   instr_decode u_decode (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_instr       (instr),
      .i_instr_valid (instr_valid),
      .o_rs1_addr    (rs1_addr),
      .o_rs2_addr    (rs2_addr),
      .issue         (issue.decode)
   );

   reg_file u_rf (
      .clk        (clk),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_we       (rf_we),
      .i_waddr    (rf_waddr),
      .i_wdata    (rf_wdata),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   serial_execute u_exec (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_rs1       (rs1),
      .i_rs2       (rs2),
      .o_res_bit   (res_bit),
      .o_res_valid (res_valid),
      .o_done      (done),
      .issue       (issue.execute)
   );

   // rs2 doubles as store data
   result_commit u_commit (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_res_bit    (res_bit),
      .i_res_valid  (res_valid),
      .i_done       (done),
      .i_store_data (rs2),
      .i_dbus_ack   (i_dbus_ack),
      .o_rf_we      (rf_we),
      .o_rf_waddr   (rf_waddr),
      .o_rf_wdata   (rf_wdata),
      .o_retire     (retire),
      .o_dbus_adr   (o_dbus_adr),
      .o_dbus_dat   (o_dbus_dat),
      .o_dbus_we    (o_dbus_we),
      .o_dbus_cyc   (o_dbus_cyc),
      .o_dbus_stb   (o_dbus_stb),
      .issue        (issue.result)
   );

endmodule

`default_nettype wire

/* tests/tb_program.svh */
localparam int    PROG_LEN     = 24;
localparam word_t UNKNOWN_WORD = 32'h0000_000b;

logic [31:0] prog [PROG_LEN];

// Reference model state
word_t model_regs [32];
word_t exp_store_adr;
word_t exp_store_dat;
logic  store_expected;
logic  model_is_store;
int    model_stores;

function automatic word_t reg_op_word(input logic [6:0] f7, input reg_addr_t rs2,
                                      input reg_addr_t rs1, input logic [2:0] f3,
                                      input reg_addr_t rd);
   return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t imm_op_word(input logic [11:0] imm, input reg_addr_t rs1,
                                      input logic [2:0] f3, input reg_addr_t rd);
   return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic word_t lui_word(input logic [19:0] imm, input reg_addr_t rd);
   return {imm, rd, 7'b0110111};
endfunction

function automatic word_t sw_word(input logic [11:0] off, input reg_addr_t rs2,
                                  input reg_addr_t rs1);
   return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
endfunction

task automatic load_program();
   prog[0]  = lui_word(20'h00001, 5'd10);
   prog[1]  = lui_word(20'h12345, 5'd1);
   prog[2]  = imm_op_word(12'h678, 5'd1, 3'b000, 5'd1);
   // -5
   prog[3]  = imm_op_word(12'hffb, 5'd0, 3'b000, 5'd2);
   prog[4]  = reg_op_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
   prog[5]  = sw_word(12'h000, 5'd3, 5'd10);
   prog[6]  = reg_op_word(7'h20, 5'd1, 5'd2, 3'b000, 5'd4);
   prog[7]  = sw_word(12'h004, 5'd4, 5'd10);
   prog[8]  = reg_op_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd5);
   prog[9]  = sw_word(12'hff8, 5'd5, 5'd10);
   prog[10] = reg_op_word(7'h00, 5'd2, 5'd1, 3'b110, 5'd6);
   prog[11] = reg_op_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd7);
   prog[12] = sw_word(12'h00c, 5'd6, 5'd10);
   prog[13] = sw_word(12'h010, 5'd7, 5'd10);
   prog[14] = imm_op_word(12'hfff, 5'd1, 3'b100, 5'd8);
   prog[15] = imm_op_word(12'h0f0, 5'd2, 3'b110, 5'd9);
   prog[16] = imm_op_word(12'hf00, 5'd1, 3'b111, 5'd11);
   // Base register holds a negative value here
   prog[17] = sw_word(12'h014, 5'd8, 5'd2);
   prog[18] = sw_word(12'h018, 5'd9, 5'd10);
   prog[19] = sw_word(12'h01c, 5'd11, 5'd10);
   prog[20] = imm_op_word(12'h007, 5'd1, 3'b000, 5'd0);
   prog[21] = sw_word(12'h020, 5'd0, 5'd10);
   // Unsupported opcode with rd = x3
   prog[22] = 32'hfff0_81fb;
   prog[23] = sw_word(12'h024, 5'd3, 5'd10);
endtask

function automatic word_t fetch_word(input word_t adr);
   word_t idx;
   idx = (adr - RESET_PC) >> 2;
   if (adr >= RESET_PC && idx < PROG_LEN) begin
      return prog[idx];
   end
   return UNKNOWN_WORD;
endfunction

function automatic word_t alu_result(input logic [2:0] f3, input logic subtract,
                                     input word_t a, input word_t b);
   case (f3)
      3'b000:  return subtract ? a - b : a + b;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
   endcase
endfunction

task automatic write_reg(input reg_addr_t rd, input word_t value);
   if (rd != 5'd0) begin
      model_regs[rd] = value;
   end
endtask

task automatic reset_model();
   for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
   end
   exp_store_adr  = '0;
   exp_store_dat  = '0;
   store_expected = 1'b0;
   model_is_store = 1'b0;
   model_stores   = 0;
   load_program();
endtask

task automatic model_execute(input word_t ins);
   reg_addr_t rd;
   word_t     a;
   word_t     b;
   word_t     imm_i;
   word_t     imm_s;
   logic      f3_ok;
   rd             = ins[11:7];
   a              = model_regs[ins[19:15]];
   b              = model_regs[ins[24:20]];
   imm_i          = {{20{ins[31]}}, ins[31:20]};
   imm_s          = {{20{ins[31]}}, ins[31:25], ins[11:7]};
   f3_ok          = ins[14:12] inside {3'b000, 3'b100, 3'b110, 3'b111};
   model_is_store = 1'b0;
   case (ins[6:0])
      7'b0110011: begin
         if (f3_ok) begin
            write_reg(rd, alu_result(ins[14:12], ins[30], a, b));
         end
      end
      7'b0010011: begin
         if (f3_ok) begin
            write_reg(rd, alu_result(ins[14:12], 1'b0, a, imm_i));
         end
      end
      7'b0110111: begin
         write_reg(rd, {ins[31:12], 12'h000});
      end
      7'b0100011: begin
         if (ins[14:12] == 3'b010) begin
            exp_store_adr  = a + imm_s;
            exp_store_dat  = b;
            store_expected = 1'b1;
            model_is_store = 1'b1;
            model_stores++;
         end
      end
      default: begin
      end
   endcase
endtask

/* tests/tb_serial_rv32.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_serial_rv32;
   import serial_rv32_pkg::*;

   localparam word_t RESET_PC    = 32'h100;
   localparam int    CLK_HALF    = 50;
   localparam int    DRIVE_DELAY = 10;

   logic  clk;
   logic  rst_n;
   word_t ibus_adr;
   logic  ibus_cyc;
   logic  ibus_stb;
   word_t ibus_dat;
   logic  ibus_ack;
   word_t dbus_adr;
   word_t dbus_dat;
   logic  dbus_we;
   logic  dbus_cyc;
   logic  dbus_stb;
   logic  dbus_ack;

   int          errors;
   int          fetches_done;
   int          stores_seen;
   word_t       exp_fetch_adr;
   int          lat_count;
   logic        lat_armed;
   logic [31:0] lfsr_state;

   `include "tb_program.svh"

   // About 60 cycles per fetched instruction, two extra fetches at the end
   localparam int WATCHDOG_NS = (PROG_LEN + 2) * 60 * 100;

   serial_rv32_top #(
      .RESET_PC (RESET_PC)
   ) DUT (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .o_ibus_stb (ibus_stb),
      .i_ibus_dat (ibus_dat),
      .i_ibus_ack (ibus_ack),
      .o_dbus_adr (dbus_adr),
      .o_dbus_dat (dbus_dat),
      .o_dbus_we  (dbus_we),
      .o_dbus_cyc (dbus_cyc),
      .o_dbus_stb (dbus_stb),
      .i_dbus_ack (dbus_ack)
   );

   always #CLK_HALF clk = ~clk;

   function automatic logic next_random_bit();
      logic out;
      out        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out) begin
         lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      return out;
   endfunction

   function automatic int ack_delay();
      int d;
      d = int'(next_random_bit());
      d = 2 * d + int'(next_random_bit());
      return d;
   endfunction

   task automatic report_value(input string test, input word_t expected, input word_t actual);
      errors++;
      $display("Error: %s expected %h actual %h at %0t", test, expected, actual, $time);
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("Failure: %s at %0t", what, $time);
   endtask

   assert property (@(posedge clk) !rst_n |=> !ibus_cyc && !dbus_cyc)
      else report_failure("a bus cycle was open during reset");

   assert property (@(posedge clk) disable iff (!rst_n) ibus_stb |-> ibus_adr == exp_fetch_adr)
      else report_value("fetch_order", $sampled(exp_fetch_adr), $sampled(ibus_adr));

   assert property (@(posedge clk) disable iff (!rst_n) dbus_stb |-> store_expected && dbus_we)
      else report_failure("data bus write without a pending store instruction");

   assert property (@(posedge clk) disable iff (!rst_n)
      dbus_stb && dbus_ack |-> dbus_adr == exp_store_adr)
      else report_value("store_addr", $sampled(exp_store_adr), $sampled(dbus_adr));

   assert property (@(posedge clk) disable iff (!rst_n)
      dbus_stb && dbus_ack |-> dbus_dat == exp_store_dat)
      else report_value("store_data", $sampled(exp_store_dat), $sampled(dbus_dat));

   // Requests hold still until acked
   assert property (@(posedge clk) disable iff (!rst_n)
      ibus_stb && !ibus_ack |=> ibus_stb && $stable(ibus_adr))
      else report_failure("instruction bus request changed while waiting for ack");

   assert property (@(posedge clk) disable iff (!rst_n)
      dbus_stb && !dbus_ack |=> dbus_stb && $stable(dbus_adr) && $stable(dbus_dat)
                                && $stable(dbus_we))
      else report_failure("data bus request changed while waiting for ack");

   assert property (@(posedge clk) disable iff (!rst_n) ibus_stb && ibus_ack |=> !ibus_stb)
      else report_failure("instruction bus strobe stayed high after its ack");

   assert property (@(posedge clk) disable iff (!rst_n) dbus_stb && dbus_ack |=> !dbus_stb)
      else report_failure("data bus strobe stayed high after its ack");

   assert property (@(posedge clk) disable iff (!rst_n) !(ibus_cyc && dbus_cyc))
      else report_failure("instruction and data bus cycles open together");

   assert property (@(posedge clk) disable iff (!rst_n)
      $rose(ibus_cyc) && lat_armed |-> lat_count == 35)
      else report_value("retire_latency", 32'd35, $sampled(lat_count));

   initial begin : ibus_slave
      int   wait_left;
      logic waiting;
      waiting   = 1'b0;
      wait_left = 0;
      forever begin
         @(posedge clk);
         #DRIVE_DELAY;
         if (ibus_ack) begin
            // Word was taken at the last edge
            ibus_ack = 1'b0;
            model_execute(ibus_dat);
            exp_fetch_adr = exp_fetch_adr + 32'd4;
            fetches_done++;
            lat_count = 1;
            lat_armed = !model_is_store;
         end else begin
            if (lat_armed) begin
               lat_count++;
            end
            if (ibus_cyc) begin
               if (!waiting) begin
                  wait_left = ack_delay();
                  waiting   = 1'b1;
               end
               if (wait_left == 0) begin
                  ibus_dat = fetch_word(ibus_adr);
                  ibus_ack = 1'b1;
                  waiting  = 1'b0;
               end else begin
                  wait_left--;
               end
            end
         end
      end
   end

   initial begin : dbus_slave
      int   wait_left;
      logic waiting;
      waiting   = 1'b0;
      wait_left = 0;
      forever begin
         @(posedge clk);
         #DRIVE_DELAY;
         if (dbus_ack) begin
            dbus_ack       = 1'b0;
            store_expected = 1'b0;
            stores_seen++;
         end else if (dbus_cyc) begin
            if (!waiting) begin
               wait_left = ack_delay();
               waiting   = 1'b1;
            end
            if (wait_left == 0) begin
               dbus_ack = 1'b1;
               waiting  = 1'b0;
            end else begin
               wait_left--;
            end
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Timeout: program did not finish in %0d ns, %0d fetches done, errors %0d",
               WATCHDOG_NS, fetches_done, errors);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      clk           = 1'b0;
      rst_n         = 1'b0;
      ibus_dat      = '0;
      ibus_ack      = 1'b0;
      dbus_ack      = 1'b0;
      errors        = 0;
      fetches_done  = 0;
      stores_seen   = 0;
      exp_fetch_adr = RESET_PC;
      lat_count     = 0;
      lat_armed     = 1'b0;
      lfsr_state    = 32'h97a1;
      reset_model();
      repeat (5) @(posedge clk);
      #DRIVE_DELAY;
      rst_n = 1'b1;
      // Two unsupported words past the end of the program
      wait (fetches_done == PROG_LEN + 2);
      repeat (2) @(posedge clk);
      assert (stores_seen == model_stores)
         else report_value("store_count", model_stores, stores_seen);
      $display("Errors: %0d, stores checked: %0d of %0d, fetches: %0d",
               errors, stores_seen, model_stores, fetches_done);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
